//--- filelist.f
vtb_data_pkg.sv
vtb_reg_pkg.sv
vtb_entry_ctrl.sv
vtb_fwd_match.sv
vtb_create_merge.sv
vtb_entry_data.sv
vtb_entry.sv
tb_vtb_entry.sv

//--- tb_vtb_entry.sv
// vtb entry testbench
`timescale 1ns/1ps

module tb_vtb_entry
  import vtb_data_pkg::*;
  import vtb_reg_pkg::*;
;

  logic   entry_clk;
  logic   cpurst_b;
  logic   create_vld, create_st, create_fls, create_wready;
  data_t  create_data;
  bmask_t create_mask, create_vl_mask;
  vreg_t  create_vreg;
  wen_t   lsu_wen;
  data_t  lsu_wen_data, fls_data, fp_wb_data;
  logic   fls_wb_vld, fp_wb_vld;
  areg_t  fls_reg, fp_wb_reg;
  logic   sseg_wb_vld, sseg_abnormal_vld, wb_done, fwd_done, flush;
  logic   entry_vld, st_vld, st_fwd_vld, st_fwd_fp_bus, fls;
  logic   wdata_ready, wdata_vld, wb_ready, wb_vld, all_wb, vload_vld;
  data_t  data;
  vreg_t  vreg;
  bmask_t vl_mask, vm_mask;

  // reference model state
  logic   m_vld, m_st, m_fls, m_ready;
  vreg_t  m_vreg;
  bmask_t m_mask, m_vl, m_bytes;
  data_t  m_data;

  // step table
  string      step_name[$];
  logic [10:0] step_ctrl[$];
  wen_t       step_wen[$];
  bmask_t     step_mask[$];
  vreg_t      step_vreg[$];
  areg_t      step_fls[$];
  areg_t      step_fp[$];
  logic [9:0] step_exp[$];

  vtb_entry dut0 (.*);

  initial
  begin
    entry_clk = 1'b0;
    forever #4 entry_clk = ~entry_clk;
  end

  initial
  begin
    cpurst_b = 1'b0;
    repeat (8) @(posedge entry_clk);
    cpurst_b <= 1'b1;
  end

  task automatic add_step(input string name, input logic [10:0] ctrl, input wen_t wen,
                          input bmask_t mask, input vreg_t vr, input areg_t flr,
                          input areg_t fpr, input logic [9:0] exp_ctl);
    step_name.push_back(name);
    step_ctrl.push_back(ctrl);
    step_wen.push_back(wen);
    step_mask.push_back(mask);
    step_vreg.push_back(vr);
    step_fls.push_back(flr);
    step_fp.push_back(fpr);
    step_exp.push_back(exp_ctl);
  endtask

  //==========================================================================
  // stimulus table
  //==========================================================================
  // ctrl bits are create vld/st/fls/wready, fls/fp bus vld, sseg wb/abn, wb/fwd done, flush
  // exp bits are entry_vld st_vld st_fwd_vld fp_bus wdata_ready wdata_vld wb_ready
  //      wb_vld all_wb vload_vld
  task automatic load_table();
    add_step("reset_idle",    11'b0000_00_00_000, 4'b0000, 8'h00, 7'h00, 5'd0,  5'd0,  10'b0000000010);
    add_step("ld_create",     11'b1000_00_00_000, 4'b0000, 8'h19, 7'h05, 5'd0,  5'd0,  10'b0000000010);
    add_step("ld_lsu_wr",     11'b0000_00_00_000, 4'b0101, 8'h00, 7'h00, 5'd0,  5'd0,  10'b1000000001);
    add_step("ld_recreate",   11'b1000_00_00_000, 4'b0000, 8'hf1, 7'h05, 5'd0,  5'd0,  10'b1000000001);
    add_step("ld_sseg_wb",    11'b0000_00_10_000, 4'b0000, 8'h00, 7'h00, 5'd0,  5'd0,  10'b1000000101);
    add_step("ld_wb_ready",   11'b0000_00_00_000, 4'b0000, 8'h00, 7'h00, 5'd0,  5'd0,  10'b1000101101);
    add_step("ld_wb_done",    11'b0000_00_00_100, 4'b0000, 8'h00, 7'h00, 5'd0,  5'd0,  10'b1000101101);
    add_step("st_create",     11'b1101_00_00_000, 4'b0000, 8'hff, 7'h10, 5'd0,  5'd0,  10'b0000100010);
    add_step("st_ready",      11'b0000_00_00_000, 4'b0000, 8'h00, 7'h00, 5'd0,  5'd0,  10'b1100110010);
    add_step("st_fwd_done",   11'b0000_00_00_010, 4'b0000, 8'h00, 7'h00, 5'd0,  5'd0,  10'b1100110010);
    add_step("fls_create",    11'b1110_00_00_000, 4'b0000, 8'hff, 7'h2d, 5'd0,  5'd0,  10'b0000100010);
    add_step("fls_miss",      11'b0000_11_00_000, 4'b0000, 8'h00, 7'h00, 5'd12, 5'd3,  10'b1100000010);
    add_step("fls_hit",       11'b0000_10_00_000, 4'b0000, 8'h00, 7'h00, 5'd11, 5'd0,  10'b1110100010);
    add_step("fls_wdata_vld", 11'b0000_00_00_000, 4'b0000, 8'h00, 7'h00, 5'd0,  5'd0,  10'b1100110010);
    add_step("fls_recreate",  11'b1110_00_00_000, 4'b0000, 8'hff, 7'h2d, 5'd0,  5'd0,  10'b1100110010);
    add_step("fls_fp_hit",    11'b0000_11_00_000, 4'b0000, 8'h00, 7'h00, 5'd11, 5'd11, 10'b1111100010);
    add_step("fls_flush",     11'b0000_00_00_001, 4'b0000, 8'h00, 7'h00, 5'd0,  5'd0,  10'b1100110010);
    add_step("flush_create",  11'b1000_00_00_001, 4'b0000, 8'h3c, 7'h08, 5'd0,  5'd0,  10'b0000100010);
    add_step("flush_idle",    11'b0000_00_00_000, 4'b0000, 8'h00, 7'h00, 5'd0,  5'd0,  10'b0000000010);
    add_step("abn_create",    11'b1000_00_00_000, 4'b0100, 8'h1f, 7'h0c, 5'd0,  5'd0,  10'b0000000010);
    add_step("abn_strobe",    11'b0000_00_01_000, 4'b0000, 8'h00, 7'h00, 5'd0,  5'd0,  10'b1000000001);
    add_step("abn_wb_ready",  11'b0000_00_00_000, 4'b0000, 8'h00, 7'h00, 5'd0,  5'd0,  10'b1000101101);
    add_step("abn_wb_done",   11'b0000_00_00_100, 4'b0010, 8'h00, 7'h00, 5'd0,  5'd0,  10'b1000101101);
    add_step("final_idle",    11'b0000_00_00_000, 4'b0000, 8'h00, 7'h00, 5'd0,  5'd0,  10'b0000100010);
  endtask

  task automatic drive_step(input int i);
    {create_vld, create_st, create_fls, create_wready, fls_wb_vld, fp_wb_vld,
     sseg_wb_vld, sseg_abnormal_vld, wb_done, fwd_done, flush} <= step_ctrl[i];
    lsu_wen        <= step_wen[i];
    create_mask    <= step_mask[i];
    create_vreg    <= step_vreg[i];
    fls_reg        <= step_fls[i];
    fp_wb_reg      <= step_fp[i];
    create_vl_mask <= $urandom;
    create_data    <= {$urandom, $urandom};
    lsu_wen_data   <= {$urandom, $urandom};
    fls_data       <= {$urandom, $urandom};
    fp_wb_data     <= {$urandom, $urandom};
  endtask

  task automatic check_val(input string step, input string what,
                           input logic [63:0] exp_v, input logic [63:0] act_v);
    assert (act_v === exp_v)
    else
    begin
      $display("Fail %s %s expected %h actual %h", step, what, exp_v, act_v);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_step(input int i);
    logic [9:0] ctl;
    ctl = {entry_vld, st_vld, st_fwd_vld, st_fwd_fp_bus, wdata_ready, wdata_vld,
           wb_ready, wb_vld, all_wb, vload_vld};
    check_val(step_name[i], "status", step_exp[i], ctl);
    check_val(step_name[i], "fls", m_fls, fls);
    check_val(step_name[i], "data", m_data, data);
    check_val(step_name[i], "vm_mask", m_mask, vm_mask);
    check_val(step_name[i], "vl_mask", m_vl, vl_mask);
    check_val(step_name[i], "vreg", m_vreg, vreg);
  endtask

  //==========================================================================
  // reference model, one clock edge
  //==========================================================================
  task automatic update_model();
    logic  fp_hit;
    logic  fls_hit;
    logic  fwd;
    data_t nd;
    fp_hit  = fp_wb_vld && (fp_wb_reg == m_vreg[vreg_w-1:areg_lsb]);
    fls_hit = fls_wb_vld && (fls_reg == m_vreg[vreg_w-1:areg_lsb]);
    fwd     = m_vld && m_st && m_fls && !m_ready && (fp_hit || fls_hit);
    nd      = m_data;
    for (int b = 0; b < byte_n; b++)
    begin
      if (create_vld)
      begin
        // same-cycle lsu block takes lsu bytes under the create mask
        if (lsu_wen[b/2])
          nd[b*8 +: 8] = create_mask[b] ? lsu_wen_data[b*8 +: 8] : create_data[b*8 +: 8];
        else if (!(m_bytes[b] && create_mask[b]))
          nd[b*8 +: 8] = create_data[b*8 +: 8];
      end
      else if (fwd)
        nd[b*8 +: 8] = fp_hit ? fp_wb_data[b*8 +: 8] : fls_data[b*8 +: 8];
      else if (lsu_wen[b/2] && (m_mask[b] || !m_vld || m_ready))
        nd[b*8 +: 8] = lsu_wen_data[b*8 +: 8];
    end
    m_data = nd;
    for (int b = 0; b < byte_n; b++)
    begin
      m_bytes[b] = lsu_wen[b/2] || (m_bytes[b] && !wb_done);
    end
    if (create_vld)
      m_ready = create_wready && create_st;
    else if (fwd || sseg_wb_vld || sseg_abnormal_vld)
      m_ready = 1'b1;
    if (wb_done)
    begin
      m_mask = '1;
      m_vl   = '1;
    end
    else if (create_vld)
    begin
      m_mask = create_mask;
      m_vl   = create_vl_mask;
    end
    if (create_vld)
    begin
      m_vreg = create_vreg;
      m_st   = create_st;
      m_fls  = create_fls;
    end
    if (wb_done || fwd_done || flush)
      m_vld = 1'b0;
    else if (create_vld)
      m_vld = 1'b1;
  endtask

  initial
  begin
    int unsigned seed_val;
    int          wait_cnt;
    seed_val = $urandom(32'h7037c519);
    {create_vld, create_st, create_fls, create_wready} = '0;
    {fls_wb_vld, fp_wb_vld, sseg_wb_vld, sseg_abnormal_vld} = '0;
    {wb_done, fwd_done, flush} = '0;
    create_data    = '0;
    create_mask    = '0;
    create_vl_mask = '0;
    create_vreg    = '0;
    lsu_wen        = '0;
    lsu_wen_data   = '0;
    fls_reg        = '0;
    fls_data       = '0;
    fp_wb_reg      = '0;
    fp_wb_data     = '0;
    {m_vld, m_st, m_fls, m_ready} = '0;
    m_vreg  = '0;
    m_mask  = '1;
    m_vl    = '1;
    m_bytes = '0;
    m_data  = 'x;
    load_table();
    wait_cnt = 0;
    while (cpurst_b !== 1'b1 && wait_cnt < 32)
    begin
      @(posedge entry_clk);
      wait_cnt++;
    end
    if (cpurst_b !== 1'b1)
    begin
      $display("reset was never released");
      $display("Simulation FAILED");
      $fatal(1);
    end
    // drive on the rising edge, sample on the falling edge
    for (int i = 0; i < step_name.size(); i++)
    begin
      @(posedge entry_clk);
      drive_step(i);
      @(negedge entry_clk);
      check_step(i);
      update_model();
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- vtb_create_merge.sv
// vtb create data merge
`timescale 1ns/1ps

module vtb_create_merge
  import vtb_data_pkg::*;
(
  input  data_t  create_data,
  input  data_t  entry_data,
  input  data_t  lsu_wen_data,
  input  bmask_t create_mask,
  input  bmask_t bytes_vld_q,
  input  wen_t   lsu_wen,
  output data_t  merge_data
);

  bmask_t held_mask;
  data_t  held_ext;
  data_t  create_ext;
  data_t  held_data;
  data_t  lsu_data;

  //==========================================================================
  // held bytes
  //==========================================================================
  // bytes the lsu already wrote stay in the entry
  assign held_mask = bytes_vld_q & create_mask;
  assign held_ext  = bmask_ext(held_mask);
  assign held_data = (create_data & ~held_ext) | (entry_data & held_ext);

  //==========================================================================
  // same-cycle lsu write
  //==========================================================================
  assign create_ext = bmask_ext(create_mask);
  assign lsu_data   = (lsu_wen_data & create_ext) | (create_data & ~create_ext);

  // pick per block
  always_comb
  begin
    for (int i = 0; i < blk_n; i++)
    begin
      if (lsu_wen[i])
        merge_data[i*blk_w +: blk_w] = lsu_data[i*blk_w +: blk_w];
      else
        merge_data[i*blk_w +: blk_w] = held_data[i*blk_w +: blk_w];
    end
  end

endmodule

//--- vtb_data_pkg.sv
// vtb entry data geometry
package vtb_data_pkg;

  // entry data word and its byte and block split
  localparam int data_w = 64;
  localparam int byte_n = 8;
  localparam int blk_n  = 4;
  localparam int blk_w  = 16;

  typedef logic [data_w-1:0] data_t;
  typedef logic [byte_n-1:0] bmask_t;
  typedef logic [blk_n-1:0]  wen_t;

  // byte mask to bit mask
  function automatic data_t bmask_ext(bmask_t m);
    data_t e;
    for (int i = 0; i < byte_n; i++)
    begin
      e[i*(data_w/byte_n) +: (data_w/byte_n)] = {(data_w/byte_n){m[i]}};
    end
    return e;
  endfunction

  // block write enable to byte mask
  function automatic bmask_t wen_ext(wen_t w);
    bmask_t e;
    for (int i = 0; i < byte_n; i++)
    begin
      e[i] = w[i/(byte_n/blk_n)];
    end
    return e;
  endfunction

endpackage

//--- vtb_entry.sv
// vtb write-back buffer entry
`timescale 1ns/1ps

module vtb_entry
  import vtb_data_pkg::*;
  import vtb_reg_pkg::*;
(
  input  logic   entry_clk,
  input  logic   cpurst_b,
  input  logic   create_vld,
  input  logic   create_st,
  input  logic   create_fls,
  input  logic   create_wready,
  input  data_t  create_data,
  input  bmask_t create_mask,
  input  bmask_t create_vl_mask,
  input  vreg_t  create_vreg,
  input  wen_t   lsu_wen,
  input  data_t  lsu_wen_data,
  input  logic   fls_wb_vld,
  input  areg_t  fls_reg,
  input  data_t  fls_data,
  input  logic   fp_wb_vld,
  input  areg_t  fp_wb_reg,
  input  data_t  fp_wb_data,
  input  logic   sseg_wb_vld,
  input  logic   sseg_abnormal_vld,
  input  logic   wb_done,
  input  logic   fwd_done,
  input  logic   flush,
  output logic   entry_vld,
  output logic   st_vld,
  output logic   st_fwd_vld,
  output logic   st_fwd_fp_bus,
  output logic   fls,
  output logic   wdata_ready,
  output logic   wdata_vld,
  output logic   wb_ready,
  output logic   wb_vld,
  output logic   all_wb,
  output logic   vload_vld,
  output data_t  data,
  output vreg_t  vreg,
  output bmask_t vl_mask,
  output bmask_t vm_mask
);

  logic   vld_q;
  logic   st_q;
  logic   fls_q;
  logic   ready_q;
  vreg_t  vreg_q;
  bmask_t mask_q;
  bmask_t mask_active;
  bmask_t bytes_vld_q;
  bmask_t vl_mask_q;
  data_t  fwd_data;
  data_t  merge_data;
  data_t  data_q;

  //==========================================================================
  // entry parts
  //==========================================================================
  vtb_entry_ctrl ctrl0 (
    .entry_clk         (entry_clk),
    .cpurst_b          (cpurst_b),
    .create_vld        (create_vld),
    .create_st         (create_st),
    .create_fls        (create_fls),
    .create_wready     (create_wready),
    .create_mask       (create_mask),
    .create_vl_mask    (create_vl_mask),
    .create_vreg       (create_vreg),
    .lsu_wen           (lsu_wen),
    .st_fwd_vld        (st_fwd_vld),
    .sseg_wb_vld       (sseg_wb_vld),
    .sseg_abnormal_vld (sseg_abnormal_vld),
    .wb_done           (wb_done),
    .fwd_done          (fwd_done),
    .flush             (flush),
    .vld_q             (vld_q),
    .st_q              (st_q),
    .fls_q             (fls_q),
    .ready_q           (ready_q),
    .vreg_q            (vreg_q),
    .mask_q            (mask_q),
    .mask_active       (mask_active),
    .bytes_vld_q       (bytes_vld_q),
    .vl_mask_q         (vl_mask_q),
    .st_vld            (st_vld),
    .wdata_ready       (wdata_ready),
    .wdata_vld         (wdata_vld),
    .wb_ready          (wb_ready),
    .wb_vld            (wb_vld),
    .all_wb            (all_wb),
    .vload_vld         (vload_vld)
  );

  vtb_fwd_match fwd0 (
    .entry_clk     (entry_clk),
    .cpurst_b      (cpurst_b),
    .vld_q         (vld_q),
    .st_q          (st_q),
    .fls_q         (fls_q),
    .ready_q       (ready_q),
    .vreg_q        (vreg_q),
    .fls_wb_vld    (fls_wb_vld),
    .fp_wb_vld     (fp_wb_vld),
    .fls_reg       (fls_reg),
    .fp_wb_reg     (fp_wb_reg),
    .fls_data      (fls_data),
    .fp_wb_data    (fp_wb_data),
    .st_fwd_vld    (st_fwd_vld),
    .st_fwd_fp_bus (st_fwd_fp_bus),
    .fwd_data      (fwd_data)
  );

  vtb_create_merge merge0 (
    .create_data  (create_data),
    .entry_data   (data_q),
    .lsu_wen_data (lsu_wen_data),
    .create_mask  (create_mask),
    .bytes_vld_q  (bytes_vld_q),
    .lsu_wen      (lsu_wen),
    .merge_data   (merge_data)
  );

  vtb_entry_data data0 (
    .entry_clk    (entry_clk),
    .cpurst_b     (cpurst_b),
    .create_vld   (create_vld),
    .st_fwd_vld   (st_fwd_vld),
    .merge_data   (merge_data),
    .fwd_data     (fwd_data),
    .lsu_wen_data (lsu_wen_data),
    .lsu_wen      (lsu_wen),
    .mask_active  (mask_active),
    .data_q       (data_q)
  );

  // register outputs
  assign entry_vld = vld_q;
  assign fls       = fls_q;
  assign data      = data_q;
  assign vreg      = vreg_q;
  assign vl_mask   = vl_mask_q;
  assign vm_mask   = mask_q;

endmodule

//--- vtb_entry_ctrl.sv
// vtb entry control state
`timescale 1ns/1ps

module vtb_entry_ctrl
  import vtb_data_pkg::*;
  import vtb_reg_pkg::*;
(
  input  logic   entry_clk,
  input  logic   cpurst_b,
  input  logic   create_vld,
  input  logic   create_st,
  input  logic   create_fls,
  input  logic   create_wready,
  input  bmask_t create_mask,
  input  bmask_t create_vl_mask,
  input  vreg_t  create_vreg,
  input  wen_t   lsu_wen,
  input  logic   st_fwd_vld,
  input  logic   sseg_wb_vld,
  input  logic   sseg_abnormal_vld,
  input  logic   wb_done,
  input  logic   fwd_done,
  input  logic   flush,
  output logic   vld_q,
  output logic   st_q,
  output logic   fls_q,
  output logic   ready_q,
  output vreg_t  vreg_q,
  output bmask_t mask_q,
  output bmask_t mask_active,
  output bmask_t bytes_vld_q,
  output bmask_t vl_mask_q,
  output logic   st_vld,
  output logic   wdata_ready,
  output logic   wdata_vld,
  output logic   wb_ready,
  output logic   wb_vld,
  output logic   all_wb,
  output logic   vload_vld
);

  logic   create_ready;
  bmask_t lsu_wen_bytes;

  assign create_ready  = create_wready && create_st;
  assign lsu_wen_bytes = wen_ext(lsu_wen);

  //==========================================================================
  // entry state
  //==========================================================================
  // release beats create
  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      vld_q <= 1'b0;
    else if (wb_done || fwd_done || flush)
      vld_q <= 1'b0;
    else if (create_vld)
      vld_q <= 1'b1;
  end

  // vm and vl masks
  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      mask_q    <= '1;
      vl_mask_q <= '1;
    end
    else if (wb_done)
    begin
      mask_q    <= '1;
      vl_mask_q <= '1;
    end
    else if (create_vld)
    begin
      mask_q    <= create_mask;
      vl_mask_q <= create_vl_mask;
    end
  end

  // bytes already written by the lsu
  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      bytes_vld_q <= '0;
    else if (wb_done)
      bytes_vld_q <= lsu_wen_bytes;
    else if (|lsu_wen)
      bytes_vld_q <= bytes_vld_q | lsu_wen_bytes;
  end

  // tag and type bits
  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      vreg_q <= '0;
      st_q   <= 1'b0;
      fls_q  <= 1'b0;
    end
    else if (create_vld)
    begin
      vreg_q <= create_vreg;
      st_q   <= create_st;
      fls_q  <= create_fls;
    end
  end

  // ready, set by forward or segment strobes
  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ready_q <= 1'b0;
    else if (create_vld)
      ready_q <= create_ready;
    else if (st_fwd_vld || sseg_wb_vld || sseg_abnormal_vld)
      ready_q <= 1'b1;
  end

  // full mask once the entry holds its data
  assign mask_active = (vld_q && !ready_q) ? mask_q : '1;

  //==========================================================================
  // status
  //==========================================================================
  assign st_vld      = vld_q && st_q;
  assign wdata_ready = ready_q || st_fwd_vld;
  assign wdata_vld   = vld_q && st_q && ready_q;
  assign wb_ready    = vld_q && !st_q && ready_q;
  assign wb_vld      = vld_q && !st_q && (ready_q || sseg_wb_vld);
  assign all_wb      = !(vld_q && !st_q);
  assign vload_vld   = vld_q && !st_q && !fls_q;

  // a flush never lets a create through
  a_flush_no_vld : assert property (
    @(posedge entry_clk) disable iff (!cpurst_b)
    flush |=> !vld_q
  );

endmodule

//--- vtb_entry_data.sv
// vtb entry data register
`timescale 1ns/1ps

module vtb_entry_data
  import vtb_data_pkg::*;
(
  input  logic   entry_clk,
  input  logic   cpurst_b,
  input  logic   create_vld,
  input  logic   st_fwd_vld,
  input  data_t  merge_data,
  input  data_t  fwd_data,
  input  data_t  lsu_wen_data,
  input  wen_t   lsu_wen,
  input  bmask_t mask_active,
  output data_t  data_q
);

  data_t active_ext;
  data_t wr_data;
  data_t data_d;

  // lsu bytes under the active mask, old bytes elsewhere
  assign active_ext = bmask_ext(mask_active);
  assign wr_data    = (lsu_wen_data & active_ext) | (data_q & ~active_ext);

  //==========================================================================
  // per block next value
  //==========================================================================
  always_comb
  begin
    for (int i = 0; i < blk_n; i++)
    begin
      if (create_vld)
        data_d[i*blk_w +: blk_w] = merge_data[i*blk_w +: blk_w];
      else if (st_fwd_vld)
        data_d[i*blk_w +: blk_w] = fwd_data[i*blk_w +: blk_w];
      else if (lsu_wen[i])
        data_d[i*blk_w +: blk_w] = wr_data[i*blk_w +: blk_w];
      else
        data_d[i*blk_w +: blk_w] = data_q[i*blk_w +: blk_w];
    end
  end

  always_ff @(posedge entry_clk)
  begin
    data_q <= data_d;
  end

  a_wen_known : assert property (
    @(posedge entry_clk) disable iff (!cpurst_b)
    !$isunknown(lsu_wen)
  );

endmodule

//--- vtb_fwd_match.sv
// vtb store data forward match
`timescale 1ns/1ps

module vtb_fwd_match
  import vtb_data_pkg::*;
  import vtb_reg_pkg::*;
(
  input  logic  entry_clk,
  input  logic  cpurst_b,
  input  logic  vld_q,
  input  logic  st_q,
  input  logic  fls_q,
  input  logic  ready_q,
  input  vreg_t vreg_q,
  input  logic  fls_wb_vld,
  input  logic  fp_wb_vld,
  input  areg_t fls_reg,
  input  areg_t fp_wb_reg,
  input  data_t fls_data,
  input  data_t fp_wb_data,
  output logic  st_fwd_vld,
  output logic  st_fwd_fp_bus,
  output data_t fwd_data
);

  areg_t entry_areg;
  logic  fls_hit;
  logic  fwd_gate;

  assign entry_areg = vreg_q[vreg_w-1:areg_lsb];

  // bus hits on the entry register
  assign fls_hit       = fls_wb_vld && (fls_reg == entry_areg);
  assign st_fwd_fp_bus = fp_wb_vld && (fp_wb_reg == entry_areg);

  // only a waiting fls store takes forwarded data
  assign fwd_gate   = vld_q && st_q && fls_q && !ready_q;
  assign st_fwd_vld = fwd_gate && (fls_hit || st_fwd_fp_bus);

  // fp bus first
  assign fwd_data = st_fwd_fp_bus ? fp_wb_data : fls_data;

  // forwarded word carries no unknown bits
  a_fwd_data_known : assert property (
    @(posedge entry_clk) disable iff (!cpurst_b)
    st_fwd_vld |-> !$isunknown(fwd_data)
  );

endmodule

//--- vtb_reg_pkg.sv
// vtb register tag types
package vtb_reg_pkg;

  // vector register tag, 7 bits
  localparam int vreg_w = 7;

  // architectural register number, taken from the tag top bits
  localparam int areg_w   = 5;
  localparam int areg_lsb = 2;

  typedef logic [vreg_w-1:0] vreg_t;
  typedef logic [areg_w-1:0] areg_t;

endpackage
